// File: cache/cache_ctrl.sv
`timescale 1ns/100ps
`include "mem_consts.svh"

module cache_ctrl (
    input  logic                    clk,
    input  logic                    rst,

    input  cache_pkg::cache_req_t   i_req,
    output cache_pkg::cache_resp_t  o_resp,

    output mem_bus_pkg::line_req_t  o_line_req,
    input  mem_bus_pkg::line_resp_t i_line_resp
);
    import mem_bus_pkg::*;
    import cache_pkg::*;

    localparam int WORD_SEL_W = `CACHE_OFFSET_W - 2;

    cache_state_t            state;

    line_t                   data_arr [`CACHE_SETS];
    tag_t                    tag_arr  [`CACHE_SETS];
    logic [`CACHE_SETS-1:0]  valid;
    logic [`CACHE_SETS-1:0]  dirty;

    tag_t                    req_tag;
    index_t                  req_index;
    logic [WORD_SEL_W-1:0]   word_sel;
    logic                    req_active;
    logic                    req_write;
    logic                    hit;

    line_t                   cur_line;
    line_t                   merged_line;
    word_t                   rdata_q;

    ////////////////////////////////////////////////////////////
    // address split and tag compare
    ////////////////////////////////////////////////////////////
    assign req_tag    = i_req.addr[`MEM_ADDR_W-1 -: `CACHE_TAG_W];
    assign req_index  = i_req.addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
    assign word_sel   = i_req.addr[`CACHE_OFFSET_W-1:2];   // word within line

    assign req_write  = |i_req.wmask;
    assign req_active = (|i_req.rmask) || req_write;
    assign hit        = valid[req_index] && (tag_arr[req_index] == req_tag);

    assign cur_line   = data_arr[req_index];

    // store bytes merged into the indexed line
    always_comb begin
        merged_line = cur_line;
        for (int b = 0; b < `MEM_WORD_W/8; b++) begin
            if (i_req.wmask[b]) begin
                merged_line[word_sel*`MEM_WORD_W + b*8 +: 8] = i_req.wdata[b*8 +: 8];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // control FSM, valid and dirty bits
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= LOOKUP;
            valid <= '0;
            dirty <= '0;
        end else begin
            case (state)
                LOOKUP: begin
                    if (req_active) begin
                        if (hit) begin
                            state <= RESPOND;
                            if (req_write) begin
                                dirty[req_index] <= 1'b1;
                            end
                        end else if (valid[req_index] && dirty[req_index]) begin
                            state <= WRITEBACK;   // victim must go out first
                        end else begin
                            state <= FILL;
                        end
                    end
                end
                WRITEBACK: begin
                    if (i_line_resp.done) begin
                        state <= FILL;
                    end
                end
                FILL: begin
                    if (i_line_resp.done) begin
                        valid[req_index] <= 1'b1;
                        dirty[req_index] <= 1'b0;
                        state            <= LOOKUP;   // replays as a hit
                    end
                end
                RESPOND: begin
                    state <= LOOKUP;
                end
                default: begin
                    state <= LOOKUP;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // data and tag arrays
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if ((state == LOOKUP) && req_active && hit) begin
            rdata_q <= merged_line[word_sel*`MEM_WORD_W +: `MEM_WORD_W];
            if (req_write) begin
                data_arr[req_index] <= merged_line;
            end
        end
        if ((state == FILL) && i_line_resp.done) begin
            data_arr[req_index] <= i_line_resp.rdata;   // install line
            tag_arr[req_index]  <= req_tag;
        end
    end

    // requester side
    assign o_resp.rdata = rdata_q;
    assign o_resp.resp  = (state == RESPOND);

    // line side, write and read never together
    always_comb begin
        o_line_req.read  = (state == FILL);
        o_line_req.write = (state == WRITEBACK);
        o_line_req.wdata = cur_line;
        if (state == WRITEBACK) begin
            o_line_req.addr = {tag_arr[req_index], req_index, {`CACHE_OFFSET_W{1'b0}}};
        end else begin
            o_line_req.addr = {req_tag, req_index, {`CACHE_OFFSET_W{1'b0}}};
        end
    end

endmodule : cache_ctrl

// File: common/cache_pkg.sv
`include "mem_consts.svh"

package cache_pkg;

    // requester side, active while either mask is nonzero
    typedef struct packed {
        mem_bus_pkg::addr_t addr;
        mem_bus_pkg::mask_t rmask;
        mem_bus_pkg::mask_t wmask;
        mem_bus_pkg::word_t wdata;
    } cache_req_t;

    typedef struct packed {
        mem_bus_pkg::word_t rdata;
        logic               resp;    // one clock
    } cache_resp_t;

    typedef logic [`CACHE_TAG_W-1:0]   tag_t;
    typedef logic [`CACHE_INDEX_W-1:0] index_t;

    typedef enum logic [1:0] {
        LOOKUP,
        WRITEBACK,   // dirty victim out
        FILL,        // new line in
        RESPOND
    } cache_state_t;

    // who drives the shared adapter
    typedef enum logic {INSTRUCTION, DATA} owner_t;

endpackage : cache_pkg

// File: common/mem_bus_pkg.sv
`include "mem_consts.svh"

package mem_bus_pkg;

    typedef logic [`MEM_ADDR_W-1:0]   addr_t;
    typedef logic [`MEM_WORD_W-1:0]   word_t;
    typedef logic [`MEM_BEAT_W-1:0]   beat_t;
    typedef logic [`MEM_LINE_W-1:0]   line_t;
    typedef logic [`MEM_WORD_W/8-1:0] mask_t;   // one bit per byte

    // cache to adapter, levels held until done
    typedef struct packed {
        addr_t addr;     // line aligned
        logic  read;
        logic  write;
        line_t wdata;
    } line_req_t;

    typedef struct packed {
        logic  done;     // single cycle pulse
        line_t rdata;
    } line_resp_t;

    // burst memory side
    typedef struct packed {
        addr_t addr;
        logic  read;
        logic  write;
        beat_t wdata;
    } bmem_req_t;

    typedef struct packed {
        logic  ready;
        addr_t raddr;
        beat_t rdata;
        logic  rvalid;
    } bmem_resp_t;

    typedef enum logic [1:0] {IDLE, READ_WAIT, WRITE_BURST, DONE} adapter_state_t;

endpackage : mem_bus_pkg

// File: common/mem_consts.svh
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

////////////////////////////////////////////////////////////
// bus widths
////////////////////////////////////////////////////////////
`define MEM_ADDR_W      32     // byte address
`define MEM_WORD_W      32     // cache port word
`define MEM_BEAT_W      64     // one burst beat
`define MEM_LINE_W      256    // one cache line
`define MEM_BEATS       4      // beats per line

////////////////////////////////////////////////////////////
// cache geometry, direct mapped
////////////////////////////////////////////////////////////
`define CACHE_SETS      16
`define CACHE_INDEX_W   4
`define CACHE_OFFSET_W  5      // byte offset in a line
`define CACHE_TAG_W     23     // addr bits above index

`endif

// File: logic/burst_adapter.sv
`timescale 1ns/100ps
`include "mem_consts.svh"

module burst_adapter (
    input  logic                    clk,
    input  logic                    rst,

    input  mem_bus_pkg::line_req_t  i_line_req,
    output mem_bus_pkg::line_resp_t o_line_resp,
    output logic                    o_idle,

    output mem_bus_pkg::bmem_req_t  o_bmem_req,
    input  mem_bus_pkg::bmem_resp_t i_bmem_resp
);
    import mem_bus_pkg::*;

    localparam int                    BEAT_CNT_W = $clog2(`MEM_BEATS);
    localparam logic [BEAT_CNT_W-1:0] LAST_BEAT  = BEAT_CNT_W'(`MEM_BEATS - 1);

    adapter_state_t         state;
    logic [BEAT_CNT_W-1:0]  beat_cnt;
    logic                   read_sent;   // read accepted by memory
    addr_t                  addr_q;
    line_t                  line_q;      // write source or read assembly

    ////////////////////////////////////////////////////////////
    // adapter FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            beat_cnt  <= '0;
            read_sent <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    beat_cnt  <= '0;
                    read_sent <= 1'b0;
                    if (i_line_req.write) begin
                        state <= WRITE_BURST;
                    end else if (i_line_req.read) begin
                        state <= READ_WAIT;
                    end
                end
                READ_WAIT: begin
                    if (!read_sent && i_bmem_resp.ready) begin
                        read_sent <= 1'b1;
                    end
                    if (i_bmem_resp.rvalid) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (beat_cnt == LAST_BEAT) begin
                            state <= DONE;
                        end
                    end
                end
                WRITE_BURST: begin
                    if (i_bmem_resp.ready) begin   // beat taken
                        beat_cnt <= beat_cnt + 1'b1;
                        if (beat_cnt == LAST_BEAT) begin
                            state <= DONE;
                        end
                    end
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // latch the line request, shift in read beats
    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            addr_q <= i_line_req.addr;
            line_q <= i_line_req.wdata;
        end else if ((state == READ_WAIT) && i_bmem_resp.rvalid) begin
            line_q <= {i_bmem_resp.rdata, line_q[`MEM_LINE_W-1:`MEM_BEAT_W]};   // beat 0 ends low
        end
    end

    ////////////////////////////////////////////////////////////
    // outputs
    ////////////////////////////////////////////////////////////
    always_comb begin
        o_bmem_req.addr   = addr_q;
        o_bmem_req.read   = (state == READ_WAIT) && !read_sent;
        o_bmem_req.write  = (state == WRITE_BURST);
        o_bmem_req.wdata  = line_q[beat_cnt*`MEM_BEAT_W +: `MEM_BEAT_W];
        o_line_resp.done  = (state == DONE);
        o_line_resp.rdata = line_q;
    end

    assign o_idle = (state == IDLE);

endmodule : burst_adapter

// File: logic/line_arbiter.sv
`timescale 1ns/100ps

module line_arbiter (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    i_adapter_idle,

    input  mem_bus_pkg::line_req_t  i_inst_line_req,
    input  mem_bus_pkg::line_req_t  i_data_line_req,
    output mem_bus_pkg::line_resp_t o_inst_line_resp,
    output mem_bus_pkg::line_resp_t o_data_line_resp,

    output mem_bus_pkg::line_req_t  o_line_req,
    input  mem_bus_pkg::line_resp_t i_line_resp
);
    import cache_pkg::*;

    owner_t owner;
    logic   inst_active;
    logic   data_active;

    assign inst_active = i_inst_line_req.read || i_inst_line_req.write;
    assign data_active = i_data_line_req.read || i_data_line_req.write;

    ////////////////////////////////////////////////////////////
    // owner FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= INSTRUCTION;
        end else begin
            case (owner)
                INSTRUCTION: begin
                    // idle adapter starts a pending instruction request this cycle
                    if (i_adapter_idle && data_active && !inst_active) begin
                        owner <= DATA;
                    end
                end
                DATA: begin
                    if (i_adapter_idle && !data_active) begin
                        owner <= INSTRUCTION;
                    end
                end
                default: begin
                    owner <= INSTRUCTION;
                end
            endcase
        end
    end

    // request mux and response steering
    always_comb begin
        o_inst_line_resp = '0;
        o_data_line_resp = '0;
        if (owner == DATA) begin
            o_line_req       = i_data_line_req;
            o_data_line_resp = i_line_resp;
        end else begin
            o_line_req       = i_inst_line_req;
            o_inst_line_resp = i_line_resp;
        end
    end

endmodule : line_arbiter

// File: logic/mem_subsystem_top.sv
`timescale 1ns/100ps

module mem_subsystem_top (
    input  logic                    clk,
    input  logic                    rst,

    input  cache_pkg::cache_req_t   i_ifetch_req,
    output cache_pkg::cache_resp_t  o_ifetch_resp,

    input  cache_pkg::cache_req_t   i_data_req,
    output cache_pkg::cache_resp_t  o_data_resp,

    output mem_bus_pkg::bmem_req_t  o_bmem_req,
    input  mem_bus_pkg::bmem_resp_t i_bmem_resp
);
    import mem_bus_pkg::*;

    line_req_t  inst_line_req;
    line_req_t  data_line_req;
    line_resp_t inst_line_resp;
    line_resp_t data_line_resp;
    line_req_t  line_req;      // owner's request
    line_resp_t line_resp;
    logic       adapter_idle;

    cache_ctrl icache0 (
        .clk         (clk),
        .rst         (rst),
        .i_req       (i_ifetch_req),
        .o_resp      (o_ifetch_resp),
        .o_line_req  (inst_line_req),
        .i_line_resp (inst_line_resp)
    );

    cache_ctrl dcache0 (
        .clk         (clk),
        .rst         (rst),
        .i_req       (i_data_req),
        .o_resp      (o_data_resp),
        .o_line_req  (data_line_req),
        .i_line_resp (data_line_resp)
    );

    line_arbiter line_arbiter0 (
        .clk              (clk),
        .rst              (rst),
        .i_adapter_idle   (adapter_idle),
        .i_inst_line_req  (inst_line_req),
        .i_data_line_req  (data_line_req),
        .o_inst_line_resp (inst_line_resp),
        .o_data_line_resp (data_line_resp),
        .o_line_req       (line_req),
        .i_line_resp      (line_resp)
    );

    burst_adapter burst_adapter0 (
        .clk         (clk),
        .rst         (rst),
        .i_line_req  (line_req),
        .o_line_resp (line_resp),
        .o_idle      (adapter_idle),
        .o_bmem_req  (o_bmem_req),
        .i_bmem_resp (i_bmem_resp)
    );

endmodule : mem_subsystem_top

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and scans the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -f verilog.f \
    --top-module tb_mem_subsystem --Mdir obj_dir -o tb_mem_subsystem

./obj_dir/tb_mem_subsystem | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation finished without failures"

// File: tb/burst_mem_model.sv
`timescale 1ns/100ps
`include "mem_consts.svh"

module burst_mem_model (
    input  logic                    clk,
    input  logic                    rst,
    input  mem_bus_pkg::bmem_req_t  i_req,
    output mem_bus_pkg::bmem_resp_t o_resp,
    input  mem_bus_pkg::addr_t      i_peek_addr,
    output mem_bus_pkg::word_t      o_peek_word,
    output int                      o_wb_count
);
    import mem_bus_pkg::*;

    localparam word_t FILL_XOR = 32'hA5A5_0000;

    beat_t      store [addr_t];   // written beats by beat address
    bmem_resp_t resp_q;           // next response to the DUT
    int         seed;
    int         rd_left;
    int         gap;
    addr_t      rd_addr;
    logic [1:0] wbeat;
    beat_t      peek_beat;

    // unwritten words hold their own address xor the fill constant
    function automatic beat_t beat_at(addr_t a);
        if (store.exists(a)) begin
            return store[a];
        end
        return {(a + 32'd4) ^ FILL_XOR, a ^ FILL_XOR};
    endfunction

    initial begin
        seed   = 32'h6be1_d3a8;
        o_resp = '0;
    end

    ////////////////////////////////////////////////////////////
    // burst protocol
    ////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        if (rst) begin
            resp_q     <= '0;
            rd_left    <= 0;
            gap        <= 0;
            wbeat      <= '0;
            o_wb_count <= 0;
        end else begin
            resp_q.ready  <= (($random(seed) & 3) != 0);   // low about one cycle in four
            resp_q.rvalid <= 1'b0;
            if (i_req.write && resp_q.ready) begin
                store[i_req.addr + {27'd0, wbeat, 3'd0}] = i_req.wdata;
                wbeat <= wbeat + 2'd1;
                if (wbeat == 2'd3) begin
                    o_wb_count <= o_wb_count + 1;   // last beat of a burst
                end
            end
            if (i_req.read && resp_q.ready && (rd_left == 0)) begin
                rd_addr <= i_req.addr;
                rd_left <= `MEM_BEATS;
                gap     <= $random(seed) & 3;
            end else if (rd_left != 0) begin
                if (gap != 0) begin
                    gap <= gap - 1;
                end else begin
                    resp_q.rvalid <= 1'b1;
                    resp_q.raddr  <= rd_addr;
                    resp_q.rdata  <= beat_at(rd_addr);
                    rd_addr       <= rd_addr + 32'd8;
                    rd_left       <= rd_left - 1;
                    gap           <= $random(seed) & 1;
                end
            end
        end
    end

    // DUT sees the response 10 ns after the edge
    always @(posedge clk) begin
        #10;
        o_resp = resp_q;
    end

    // word lookup for the testbench
    always @(posedge clk) begin
        peek_beat   = beat_at({i_peek_addr[31:3], 3'b000});
        o_peek_word <= i_peek_addr[2] ? peek_beat[63:32] : peek_beat[31:0];
    end

endmodule : burst_mem_model

// File: tb/mem_testdata.txt
// port addr wmask wdata expected
// port 0 ifetch, 1 data, 2 ifetch with next data line, 3 memory word (wdata = writebacks), f end
0 00001000 0 00000000 a5a51000
0 00001000 0 00000000 a5a51000
0 00001004 0 00000000 a5a51004
0 0000101c 0 00000000 a5a5101c
1 00002040 0 00000000 a5a52040
1 00002040 3 11223344 00000000
1 00002040 0 00000000 a5a53344
1 00002048 8 de000000 00000000
1 00002048 0 00000000 dea52048
1 00002044 0 00000000 a5a52044
1 00002240 0 00000000 a5a52240
3 00002040 0 00000001 a5a53344
3 00002044 0 00000001 a5a52044
3 00002048 0 00000001 dea52048
1 00002040 0 00000000 a5a53344
0 00002048 0 00000000 dea52048
1 00003060 f cafef00d 00000000
1 00003260 0 00000000 a5a53260
3 00003060 0 00000002 cafef00d
0 00003060 0 00000000 cafef00d
2 00004000 0 00000000 a5a54000
1 00005020 0 00000000 a5a55020
2 00001004 0 00000000 a5a51004
1 00005024 f 01234567 00000000
1 00005024 0 00000000 01234567
2 00006000 0 00000000 a5a56000
1 00007000 0 00000000 a5a57000
3 00005024 0 00000002 a5a55024
f 00000000 0 00000000 00000000

// File: tb/tb_mem_subsystem.sv
`timescale 1ns/100ps

module tb_mem_subsystem;
    import mem_bus_pkg::*;
    import cache_pkg::*;

    localparam int MAX_OPS = 64;

    logic        clk;
    logic        rst;
    cache_req_t  ifetch_req;
    cache_resp_t ifetch_resp;
    cache_req_t  data_req;
    cache_resp_t data_resp;
    bmem_req_t   bmem_req;
    bmem_resp_t  bmem_resp;
    addr_t       peek_addr;
    word_t       peek_word;
    int          wb_count;
    logic [31:0] testdata [MAX_OPS*5];   // five columns per operation

    mem_subsystem_top dut0 (
        .clk           (clk),
        .rst           (rst),
        .i_ifetch_req  (ifetch_req),
        .o_ifetch_resp (ifetch_resp),
        .i_data_req    (data_req),
        .o_data_resp   (data_resp),
        .o_bmem_req    (bmem_req),
        .i_bmem_resp   (bmem_resp)
    );

    burst_mem_model mem0 (
        .clk         (clk),
        .rst         (rst),
        .i_req       (bmem_req),
        .o_resp      (bmem_resp),
        .i_peek_addr (peek_addr),
        .o_peek_word (peek_word),
        .o_wb_count  (wb_count)
    );

    always #50 clk = ~clk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            report_failure($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
        end
    endtask

    function automatic word_t pattern_word(addr_t a);
        return a ^ 32'hA5A5_0000;
    endfunction

    task automatic check_quiet(input string name);
        check_value({name, " ifetch resp"}, 32'd0, {31'd0, ifetch_resp.resp});
        check_value({name, " data resp"}, 32'd0, {31'd0, data_resp.resp});
        check_value({name, " bmem read"}, 32'd0, {31'd0, bmem_req.read});
        check_value({name, " bmem write"}, 32'd0, {31'd0, bmem_req.write});
    endtask

    // request held on one port until resp pulses
    task automatic run_access(input logic is_data, input addr_t addr, input mask_t wmask,
                              input word_t wdata, output word_t rdata);
        cache_req_t  req;
        cache_resp_t resp;
        bit          seen;
        req.addr  = addr;
        req.rmask = (wmask == '0) ? 4'hF : 4'h0;
        req.wmask = wmask;
        req.wdata = wdata;
        seen      = 1'b0;
        rdata     = '0;
        if (is_data) data_req = req;
        else ifetch_req = req;
        for (int i = 0; (i < 2000) && !seen; i++) begin
            @(posedge clk);
            #10;
            resp = is_data ? data_resp : ifetch_resp;
            if (resp.resp) begin
                seen  = 1'b1;
                rdata = resp.rdata;
            end
        end
        if (!seen) begin
            report_failure(is_data ? "data port never responded"
                                   : "instruction port never responded");
        end
        @(posedge clk);
        #10;
        if (is_data) data_req = '0;
        else ifetch_req = '0;
    endtask

    initial begin
        logic [31:0] port;
        addr_t       addr;
        mask_t       wmask;
        word_t       wdata;
        word_t       expected;
        word_t       rdata;
        word_t       rdata_d;
        string       name;
        clk        = 1'b0;
        rst        = 1'b1;
        ifetch_req = '0;
        data_req   = '0;
        peek_addr  = '0;
        $readmemh("tb/mem_testdata.txt", testdata);

        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #10;
            check_quiet("reset");
        end
        rst = 1'b0;
        @(posedge clk);
        #10;
        check_quiet("after reset");

        ////////////////////////////////////////////////////////////
        // operations from the data file
        ////////////////////////////////////////////////////////////
        for (int op = 0; op < MAX_OPS; op++) begin
            port     = testdata[op*5];
            addr     = testdata[op*5+1];
            wmask    = testdata[op*5+2][3:0];
            wdata    = testdata[op*5+3];
            expected = testdata[op*5+4];
            name     = $sformatf("op %0d addr %h", op, addr);
            if (port == 32'hF) break;   // end marker
            case (port)
                32'd0, 32'd1: begin
                    run_access(port[0], addr, wmask, wdata, rdata);
                    if (wmask == '0) check_value(name, expected, rdata);
                    if (op == 0) check_value({name, " pattern"}, pattern_word(addr), rdata);
                end
                32'd2: begin   // paired with the data op on the next line
                    fork
                        run_access(1'b0, addr, '0, '0, rdata);
                        run_access(1'b1, testdata[op*5+6], testdata[op*5+7][3:0],
                                   testdata[op*5+8], rdata_d);
                    join
                    check_value(name, expected, rdata);
                    if (testdata[op*5+7][3:0] == 4'h0) begin
                        check_value({name, " data"}, testdata[op*5+9], rdata_d);
                    end
                    op++;
                end
                32'd3: begin
                    peek_addr = addr;
                    repeat (2) @(posedge clk);
                    #10;
                    check_value({name, " memory"}, expected, peek_word);
                    check_value({name, " writebacks"}, wdata, wb_count);
                end
                default: begin
                    report_failure($sformatf("unknown port code %h in test data", port));
                end
            endcase
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule : tb_mem_subsystem

// File: verilog.f
+incdir+common
common/mem_bus_pkg.sv
common/cache_pkg.sv
cache/cache_ctrl.sv
logic/line_arbiter.sv
logic/burst_adapter.sv
logic/mem_subsystem_top.sv
tb/burst_mem_model.sv
tb/tb_mem_subsystem.sv
